// File: rom_download.f
+incdir+.
rom_download_pkg.sv
rom_stage_if.sv
rom_header_parser.sv
rom_addr_mapper.sv
rom_target_writer.sv
rom_download.sv
rom_download_checker.sv
tb_rom_download.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ROM download testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f rom_download.f --top-module tb_rom_download \
    -o tb_rom_download > sim.log 2>&1 \
    && ./obj_dir/tb_rom_download >> sim.log 2>&1 \
    || echo "Checks failed" >> sim.log
cat sim.log
if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0

// File: tb_rom_download.sv
//======================================================================
// Testbench top with clock, reset, record table host driver,
// SDRAM acknowledge responder and cycle limit
//======================================================================

`include "rom_download_macros.svh"

module tb_rom_download import rom_download_pkg::*; ();

    // One row per record, a new download first sends its config byte
    typedef struct packed {
        logic        new_dl;
        logic [7:0]  cfg;
        logic [7:0]  idx;
        logic [23:0] size;
        logic [7:0]  seed;
    } rec_t;

    localparam int NUM_RECS = 10;

    localparam rec_t REC_TABLE [NUM_RECS] = '{
        // New download into plain SDRAM region 0
        '{1'b1, 8'h5a, 8'h00, 24'd20,  8'h11},
        // Reordered region 1 across several 128-byte blocks
        '{1'b0, 8'h00, 8'h01, 24'd200, 8'h23},
        // Block RAM region 4, then 0xff steps to 5, 6 (empty) and 7
        '{1'b0, 8'h00, 8'h04, 24'd40,  8'h35},
        '{1'b0, 8'h00, 8'hff, 24'd16,  8'h47},
        '{1'b0, 8'h00, 8'hff, 24'd0,   8'h59},
        '{1'b0, 8'h00, 8'hff, 24'd12,  8'h6b},
        // Restarted download with another config into reordered region 3
        '{1'b1, 8'hc3, 8'h03, 24'd150, 8'h7d},
        '{1'b0, 8'h00, 8'h02, 24'd24,  8'h8f},
        // After a restart 0xff starts over from region 0
        '{1'b1, 8'h17, 8'hff, 24'd8,   8'h91},
        '{1'b0, 8'h00, 8'h09, 24'd6,   8'ha3}
    };

    logic                         sys_clk;
    logic                         rst;
    logic                         ioctl_downl;
    logic                         ioctl_wr;
    logic [7:0]                   ioctl_data;
    logic                         ioctl_wait;
    logic [`ROM_SDR_ADDR_W-1:0]   sdr_addr;
    logic [15:0]                  sdr_data;
    logic [1:0]                   sdr_be;
    logic                         sdr_req;
    logic                         sdr_ack;
    logic [`ROM_BRAM_ADDR_W-1:0]  bram_addr;
    logic [7:0]                   bram_data;
    logic [`ROM_BRAM_CS_W-1:0]    bram_cs;
    logic                         bram_wr;
    board_cfg_t                   board_cfg;
    // Host side notes for the checker
    logic                         exp_push;
    logic [`ROM_REGION_IDX_W-1:0] exp_region;
    logic [`ROM_SIZE_W-1:0]       exp_offset;
    logic [7:0]                   exp_data;
    logic [7:0]                   exp_cfg;
    logic                         rec_mark;
    int                           rec_id;
    logic                         run_done;
    int                           error_count;
    int                           queued;
    logic [`ROM_REGION_IDX_W-1:0] cur_region;
    integer                       seed = 71;

    rom_download rom_download_inst (.*);

    rom_download_checker checker_inst (.*);

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    function automatic int table_bytes();
        int total;
        total = 0;
        for (int r = 0; r < NUM_RECS; r++)
            total = total + 4 + int'(REC_TABLE[r].size) + int'(REC_TABLE[r].new_dl);
        return total;
    endfunction

    // Offer one byte to the DUT, holding off while ioctl_wait is high
    task automatic send_byte(input logic [7:0] value, input logic is_data,
                             input logic [`ROM_SIZE_W-1:0] offset);
        while (ioctl_wait) begin
            @(posedge sys_clk);
            #1;
        end
        ioctl_wr = 1'b1;
        ioctl_data = value;
        exp_push = is_data;
        exp_region = cur_region;
        exp_offset = offset;
        exp_data = value;
        @(posedge sys_clk);
        #1;
        ioctl_wr = 1'b0;
        exp_push = 1'b0;
    endtask

    task automatic run_record(input int r);
        rec_t rec;
        rec = REC_TABLE[r];
        if (rec.new_dl) begin
            // Dropping the download level restarts the image
            ioctl_downl = 1'b0;
            repeat (3) @(posedge sys_clk);
            #1;
            ioctl_downl = 1'b1;
            cur_region = '0;
            exp_cfg = rec.cfg;
            send_byte(rec.cfg, 1'b0, '0);
        end
        if (rec.idx == 8'hff)
            cur_region = cur_region + 1'b1;
        else
            cur_region = rec.idx[`ROM_REGION_IDX_W-1:0];
        send_byte(rec.idx, 1'b0, '0);
        send_byte(rec.size[23:16], 1'b0, '0);
        send_byte(rec.size[15:8], 1'b0, '0);
        send_byte(rec.size[7:0], 1'b0, '0);
        for (int k = 0; k < int'(rec.size); k++)
            send_byte((rec.seed * 8'd29 + 8'(k * 7)) ^ 8'(k >> 5), 1'b1, `ROM_SIZE_W'(k));
        // Drain the pipeline before the record result is printed
        while (queued != 0 || ioctl_wait) begin
            @(posedge sys_clk);
            #1;
        end
        repeat (4) @(posedge sys_clk);
        #1;
        rec_id = r;
        rec_mark = 1'b1;
        @(posedge sys_clk);
        #1;
        rec_mark = 1'b0;
    endtask

    // SDRAM stand-in answers each toggle after 1 to 6 cycles
    initial begin
        int delay;
        sdr_ack = 1'b0;
        forever begin
            @(posedge sys_clk);
            #1;
            if (sdr_req != sdr_ack) begin
                delay = 1 + ({$random(seed)} % 6);
                repeat (delay) @(posedge sys_clk);
                #1;
                sdr_ack = sdr_req;
            end
        end
    end

    initial begin
        rst = 1'b1;
        ioctl_downl = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_data = 8'h00;
        exp_push = 1'b0;
        exp_region = '0;
        exp_offset = '0;
        exp_data = 8'h00;
        exp_cfg = 8'h00;
        rec_mark = 1'b0;
        rec_id = 0;
        run_done = 1'b0;
        cur_region = '0;
        repeat (8) @(posedge sys_clk);
        #1;
        rst = 1'b0;
        for (int r = 0; r < NUM_RECS; r++)
            run_record(r);
        ioctl_downl = 1'b0;
        run_done = 1'b1;
        @(posedge sys_clk);
        #1;
        run_done = 1'b0;
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // Ten cycles per byte covers the slowest acknowledge, plus setup margin
    initial begin
        int cycles;
        int limit;
        cycles = 0;
        limit = table_bytes() * 10 + 200;
        while (cycles < limit) begin
            @(posedge sys_clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: rom_download_checker.sv
//======================================================================
// Testbench checker with the expected write queue, address prediction,
// back-pressure watch and the per-record and closing result lines
//======================================================================

`include "rom_download_macros.svh"

module rom_download_checker import rom_download_pkg::*; (
    input  logic                         sys_clk,
    input  logic                         rst,
    input  logic                         exp_push,
    input  logic [`ROM_REGION_IDX_W-1:0] exp_region,
    input  logic [`ROM_SIZE_W-1:0]       exp_offset,
    input  logic [7:0]                   exp_data,
    input  logic [7:0]                   exp_cfg,
    input  logic                         rec_mark,
    input  int                           rec_id,
    input  logic                         run_done,
    input  logic                         ioctl_wait,
    input  logic [`ROM_SDR_ADDR_W-1:0]   sdr_addr,
    input  logic [15:0]                  sdr_data,
    input  logic [1:0]                   sdr_be,
    input  logic                         sdr_req,
    input  logic                         sdr_ack,
    input  logic [`ROM_BRAM_ADDR_W-1:0]  bram_addr,
    input  logic [7:0]                   bram_data,
    input  logic [`ROM_BRAM_CS_W-1:0]    bram_cs,
    input  logic                         bram_wr,
    input  board_cfg_t                   board_cfg,
    output int                           error_count,
    output int                           queued
);

    // Reference of host bytes that still owe a memory write, oldest first
    logic [`ROM_SDR_ADDR_W-1:0] addr_q [$];
    logic [7:0]                 data_q [$];
    logic [`ROM_BRAM_CS_W-1:0]  cs_q [$];
    logic [1:0]                 be_q [$];
    logic                       seen_req;
    int                         rec_writes;
    int                         rec_errors;
    int                         total_writes;
    int                         rec_count;

    task automatic count_error(input string line);
        error_count++;
        rec_errors++;
        $display("%s", line);
    endtask

    // SDRAM bytes land at base plus offset, reordered regions move offset
    // bit 6 down to bit 2 and lift bits 5..2 by one, block RAMs use the offset
    function automatic logic [`ROM_SDR_ADDR_W-1:0] predict_addr(
        input logic [`ROM_REGION_IDX_W-1:0] region,
        input logic [`ROM_SIZE_W-1:0]       offset
    );
        logic [`ROM_SDR_ADDR_W-1:0] off;
        off = `ROM_SDR_ADDR_W'(offset);
        if (LOAD_REGIONS[region].bram_cs != '0)
            return `ROM_SDR_ADDR_W'(offset[`ROM_BRAM_ADDR_W-1:0]);
        if (LOAD_REGIONS[region].reorder_64)
            off = (off & ~25'h7c) | ((off >> 4) & 25'h4) | ((off << 1) & 25'h78);
        return LOAD_REGIONS[region].base_addr + off;
    endfunction

    task automatic compare_write(
        input logic                        sdram,
        input logic [`ROM_SDR_ADDR_W-1:0]  addr,
        input logic [15:0]                 data,
        input logic [1:0]                  be,
        input logic [`ROM_BRAM_CS_W-1:0]   cs
    );
        logic [`ROM_SDR_ADDR_W-1:0] e_addr;
        logic [7:0]                 e_data;
        logic [`ROM_BRAM_CS_W-1:0]  e_cs;
        logic [1:0]                 e_be;
        rec_writes++;
        total_writes++;
        if (addr_q.size() == 0) begin
            count_error($sformatf("a write appeared at time %0t with no host byte left", $time));
            return;
        end
        e_addr = addr_q.pop_front();
        e_data = data_q.pop_front();
        e_cs = cs_q.pop_front();
        e_be = be_q.pop_front();
        // Byte lanes only mean something on the SDRAM side
        if (!sdram)
            e_be = be;
        if (sdram != (e_cs == '0) || addr != e_addr || data != {e_data, e_data}
                || be != e_be || cs != e_cs)
            count_error($sformatf({"mismatch at time %0t: sdram %b addr %h data %h be %b cs %b,",
                " expected addr %h data %h be %b cs %b"}, $time, sdram, addr, data, be, cs,
                e_addr, {e_data, e_data}, e_be, e_cs));
    endtask

    //==================================================================
    // Sampling on the falling edge, where all DUT outputs are settled
    //==================================================================
    always @(negedge sys_clk) begin
        if (rst) begin
            seen_req = 1'b0;
            error_count = 0;
            rec_errors = 0;
            rec_writes = 0;
            total_writes = 0;
            rec_count = 0;
        end else begin
            if (exp_push) begin
                addr_q.push_back(predict_addr(exp_region, exp_offset));
                data_q.push_back(exp_data);
                cs_q.push_back(LOAD_REGIONS[exp_region].bram_cs);
                // Odd offsets use the upper lane
                be_q.push_back(exp_offset[0] ? 2'b10 : 2'b01);
            end
            // Every request toggle is one SDRAM write
            if (sdr_req != seen_req) begin
                seen_req = sdr_req;
                compare_write(1'b1, sdr_addr, sdr_data, sdr_be, '0);
            end
            if (bram_wr)
                compare_write(1'b0, `ROM_SDR_ADDR_W'(bram_addr), {bram_data, bram_data},
                              2'b00, bram_cs);
            if (sdr_req != sdr_ack && !ioctl_wait)
                count_error($sformatf("ioctl_wait was low at time %0t with an open SDRAM write",
                                      $time));
            if (rec_mark) begin
                if (board_cfg != board_cfg_t'(exp_cfg))
                    count_error($sformatf("mismatch at time %0t: board_cfg %h, expected %h",
                                          $time, board_cfg, exp_cfg));
                $display("record %0d: %0d writes, %0d errors", rec_id, rec_writes, rec_errors);
                rec_count++;
                rec_writes = 0;
                rec_errors = 0;
            end
            if (run_done) begin
                if (addr_q.size() != 0)
                    count_error($sformatf("%0d host bytes never reached a memory",
                                          addr_q.size()));
                $display("records %0d, writes %0d, errors %0d",
                         rec_count, total_writes, error_count);
            end
            queued = addr_q.size();
        end
    end

endmodule

// File: rom_download.sv
//====================================================================
// ROM download top level with parser, mapper and writer stages
//====================================================================

`include "rom_download_macros.svh"

module rom_download import rom_download_pkg::*; (
    input  logic                        sys_clk,
    input  logic                        rst,
    input  logic                        ioctl_downl,
    input  logic                        ioctl_wr,
    input  logic [7:0]                  ioctl_data,
    output logic                        ioctl_wait,
    output logic [`ROM_SDR_ADDR_W-1:0]  sdr_addr,
    output logic [15:0]                 sdr_data,
    output logic [1:0]                  sdr_be,
    output logic                        sdr_req,
    input  logic                        sdr_ack,
    output logic [`ROM_BRAM_ADDR_W-1:0] bram_addr,
    output logic [7:0]                  bram_data,
    output logic [`ROM_BRAM_CS_W-1:0]   bram_cs,
    output logic                        bram_wr,
    output board_cfg_t                  board_cfg
);

    // Writer tells the parser that an SDRAM write is still open
    logic sdr_pending;

    rom_beat_if  beat_bus ();
    rom_write_if wr_bus ();

    // Stage 1 takes host bytes and emits one beat per data byte
    rom_header_parser parser_inst (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .ioctl_downl (ioctl_downl),
        .ioctl_wr    (ioctl_wr),
        .ioctl_data  (ioctl_data),
        .ioctl_wait  (ioctl_wait),
        .board_cfg   (board_cfg),
        .sdr_pending (sdr_pending),
        .beat        (beat_bus)
    );

    // Stage 2 turns region and offset into a target address
    rom_addr_mapper mapper_inst (
        .sys_clk (sys_clk),
        .rst     (rst),
        .beat    (beat_bus),
        .wr      (wr_bus)
    );

    // Stage 3 drives the SDRAM and block RAM write ports
    rom_target_writer writer_inst (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .wr          (wr_bus),
        .sdr_addr    (sdr_addr),
        .sdr_data    (sdr_data),
        .sdr_be      (sdr_be),
        .sdr_req     (sdr_req),
        .sdr_ack     (sdr_ack),
        .bram_addr   (bram_addr),
        .bram_data   (bram_data),
        .bram_cs     (bram_cs),
        .bram_wr     (bram_wr),
        .sdr_pending (sdr_pending)
    );

endmodule

// File: rom_target_writer.sv
//====================================================================
// SDRAM toggle request and block RAM write pulse generation
//====================================================================

`include "rom_download_macros.svh"

module rom_target_writer (
    input  logic                        sys_clk,
    input  logic                        rst,
    rom_write_if.writer_side            wr,
    output logic [`ROM_SDR_ADDR_W-1:0]  sdr_addr,
    output logic [15:0]                 sdr_data,
    output logic [1:0]                  sdr_be,
    output logic                        sdr_req,
    input  logic                        sdr_ack,
    output logic [`ROM_BRAM_ADDR_W-1:0] bram_addr,
    output logic [7:0]                  bram_data,
    output logic [`ROM_BRAM_CS_W-1:0]   bram_cs,
    output logic                        bram_wr,
    output logic                        sdr_pending
);

    logic sdr_write;
    logic bram_write;

    assign sdr_write = wr.wr_valid & wr.wr_sdram;
    assign bram_write = wr.wr_valid & ~wr.wr_sdram;

    // The SDRAM side owes an acknowledge while req and ack disagree
    assign sdr_pending = sdr_req ^ sdr_ack;

    //================================================================
    // Request toggle, write pulse and chip select
    //================================================================
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            sdr_req <= 1'b0;
            bram_wr <= 1'b0;
            bram_cs <= '0;
        end else begin
            bram_wr <= bram_write;
            // Each SDRAM write flips the request exactly once
            if (sdr_write)
                sdr_req <= ~sdr_req;
            // Chip select holds after the pulse until the next write
            if (bram_write)
                bram_cs <= wr.wr_cs;
        end
    end

    //================================================================
    // Address and data registers
    //================================================================
    always_ff @(posedge sys_clk) begin
        if (sdr_write) begin
            sdr_addr <= wr.wr_addr;
            // Byte goes on both halves, the lane enable picks one
            sdr_data <= {wr.wr_data, wr.wr_data};
            sdr_be <= {wr.wr_addr[0], ~wr.wr_addr[0]};
        end
        if (bram_write) begin
            bram_addr <= wr.wr_addr[`ROM_BRAM_ADDR_W-1:0];
            bram_data <= wr.wr_data;
        end
    end

endmodule

// File: rom_addr_mapper.sv
//====================================================================
// Region lookup and SDRAM or block RAM address forming
//====================================================================

`include "rom_download_macros.svh"

module rom_addr_mapper import rom_download_pkg::*; (
    input  logic             sys_clk,
    input  logic             rst,
    rom_beat_if.mapper_side  beat,
    rom_write_if.mapper_side wr
);

    region_desc_t                desc;
    logic [`ROM_SDR_ADDR_W-1:0]  offset_ext;
    logic [`ROM_SDR_ADDR_W-1:0]  offset_map;
    logic [`ROM_SDR_ADDR_W-1:0]  bram_addr_ext;
    logic                        to_sdram;

    // Descriptor of the region that the current beat belongs to
    assign desc = LOAD_REGIONS[beat.beat_region];

    // Any chip select bit means the byte stays on chip
    assign to_sdram = (desc.bram_cs == '0);

    assign offset_ext = `ROM_SDR_ADDR_W'(beat.beat_offset);

    // Reordered regions move offset bit 6 down to bit 2
    // Bits 5..2 shift up by one to make room
    assign offset_map = desc.reorder_64 ?
        {offset_ext[`ROM_SDR_ADDR_W-1:7], offset_ext[5:2], offset_ext[6], offset_ext[1:0]} :
        offset_ext;

    // Block RAMs are addressed from zero by the low offset bits
    assign bram_addr_ext = `ROM_SDR_ADDR_W'(beat.beat_offset[`ROM_BRAM_ADDR_W-1:0]);

    // One write strobe per beat, one cycle later
    always_ff @(posedge sys_clk) begin
        if (rst)
            wr.wr_valid <= 1'b0;
        else
            wr.wr_valid <= beat.beat_valid;
    end

    // Resolved target, address and data for the writer
    always_ff @(posedge sys_clk) begin
        if (beat.beat_valid) begin
            wr.wr_sdram <= to_sdram;
            wr.wr_data <= beat.beat_data;
            wr.wr_cs <= desc.bram_cs;
            if (to_sdram)
                wr.wr_addr <= desc.base_addr + offset_map;
            else
                wr.wr_addr <= bram_addr_ext;
        end
    end

endmodule

// File: rom_header_parser.sv
//====================================================================
// Download stream parser with record header FSM and host wait level
//====================================================================

`include "rom_download_macros.svh"

module rom_header_parser import rom_download_pkg::*; (
    input  logic                 sys_clk,
    input  logic                 rst,
    input  logic                 ioctl_downl,
    input  logic                 ioctl_wr,
    input  logic [7:0]           ioctl_data,
    output logic                 ioctl_wait,
    output board_cfg_t           board_cfg,
    input  logic                 sdr_pending,
    rom_beat_if.parser_side      beat
);

    parse_state_e                  state;
    logic [`ROM_REGION_IDX_W-1:0]  region;
    logic [`ROM_SIZE_W-1:0]        size;
    logic [`ROM_SIZE_W-1:0]        offset;
    logic                          data_to_sdram;
    logic [1:0]                    sdr_flight;
    logic                          take_byte;
    logic                          take_sdr_byte;
    logic                          last_byte;
    logic [`ROM_SIZE_W-1:0]        size_next;

    // A byte is only taken while a download is active
    assign take_byte = ioctl_downl & ioctl_wr;

    // Data bytes headed for SDRAM start the back-pressure sequence
    assign take_sdr_byte = take_byte & (state == DATA) & data_to_sdram;

    assign last_byte = (offset == size - `ROM_SIZE_W'(1));

    // Full size as it stands once the low size byte arrives
    assign size_next = {size[`ROM_SIZE_W-1:8], ioctl_data};

    //================================================================
    // Control FSM
    //================================================================
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            state <= BOARD_CFG;
            region <= '0;
            board_cfg <= '0;
            beat.beat_valid <= 1'b0;
            sdr_flight <= '0;
            ioctl_wait <= 1'b0;
        end else begin
            beat.beat_valid <= 1'b0;

            // Flight bits follow an SDRAM byte through mapper and writer
            sdr_flight <= {sdr_flight[0], take_sdr_byte};

            // After the writer toggles, the open request holds the wait
            ioctl_wait <= take_sdr_byte | (|sdr_flight) | sdr_pending;

            if (!ioctl_downl) begin
                state <= BOARD_CFG;
                region <= '0;
            end else if (ioctl_wr) begin
                case (state)
                    BOARD_CFG: begin
                        board_cfg <= board_cfg_t'(ioctl_data);
                        state <= REGION_IDX;
                    end
                    REGION_IDX: begin
                        // 0xff continues with the next region in the table
                        if (ioctl_data == 8'hff)
                            region <= region + 1'b1;
                        else
                            region <= ioctl_data[`ROM_REGION_IDX_W-1:0];
                        state <= SIZE_0;
                    end
                    SIZE_0: state <= SIZE_1;
                    SIZE_1: state <= SIZE_2;
                    SIZE_2: begin
                        // Empty records carry no data and are skipped
                        if (size_next == '0)
                            state <= REGION_IDX;
                        else
                            state <= DATA;
                    end
                    DATA: begin
                        beat.beat_valid <= 1'b1;
                        if (last_byte)
                            state <= REGION_IDX;
                    end
                    default: state <= BOARD_CFG;
                endcase
            end
        end
    end

    //================================================================
    // Size, offset and beat payload
    //================================================================
    always_ff @(posedge sys_clk) begin
        if (take_byte) begin
            case (state)
                SIZE_0: size[23:16] <= ioctl_data;
                SIZE_1: size[15:8] <= ioctl_data;
                SIZE_2: begin
                    size[7:0] <= ioctl_data;
                    offset <= '0;
                    // Target is fixed per record, so look it up once here
                    data_to_sdram <= (LOAD_REGIONS[region].bram_cs == '0);
                end
                DATA: begin
                    beat.beat_data <= ioctl_data;
                    beat.beat_offset <= offset;
                    beat.beat_region <= region;
                    offset <= offset + 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: rom_stage_if.sv
//====================================================================
// Parser to mapper beat bus and mapper to writer write bus
//====================================================================

`include "rom_download_macros.svh"

// One data byte with its region and running offset
interface rom_beat_if;
    logic                          beat_valid;
    logic [7:0]                    beat_data;
    logic [`ROM_SIZE_W-1:0]        beat_offset;
    logic [`ROM_REGION_IDX_W-1:0]  beat_region;

    modport parser_side (
        output beat_valid, beat_data, beat_offset, beat_region
    );

    modport mapper_side (
        input beat_valid, beat_data, beat_offset, beat_region
    );
endinterface

// A resolved write, either SDRAM byte address or block RAM address
interface rom_write_if;
    logic                        wr_valid;
    logic                        wr_sdram;
    logic [`ROM_SDR_ADDR_W-1:0]  wr_addr;
    logic [7:0]                  wr_data;
    logic [`ROM_BRAM_CS_W-1:0]   wr_cs;

    modport mapper_side (
        output wr_valid, wr_sdram, wr_addr, wr_data, wr_cs
    );

    modport writer_side (
        input wr_valid, wr_sdram, wr_addr, wr_data, wr_cs
    );
endinterface

// File: rom_download_pkg.sv
//====================================================================
// Board configuration, region descriptor, parser states, region table
//====================================================================

`include "rom_download_macros.svh"

package rom_download_pkg;

    // Board variant byte, sent first in every download image
    typedef struct packed {
        logic [2:0] mem_map;
        logic [1:0] sound_variant;
        logic [2:0] option_flags;
    } board_cfg_t;

    // One entry of the load region table
    // A nonzero chip select marks a block RAM target
    typedef struct packed {
        logic [`ROM_SDR_ADDR_W-1:0] base_addr;
        logic                       reorder_64;
        logic [`ROM_BRAM_CS_W-1:0]  bram_cs;
    } region_desc_t;

    // Header parser FSM states
    typedef enum logic [2:0] {
        BOARD_CFG,
        REGION_IDX,
        SIZE_0,
        SIZE_1,
        SIZE_2,
        DATA
    } parse_state_e;

    // Regions 0 to 3 go to SDRAM, 1 and 3 use the 64-byte reorder
    // Regions 4 to 7 each own one block RAM
    // Regions 8 to 15 are spare SDRAM windows
    localparam region_desc_t LOAD_REGIONS [`ROM_REGION_COUNT] = '{
        '{base_addr: 25'h000_0000, reorder_64: 1'b0, bram_cs: 4'b0000},
        '{base_addr: 25'h010_0000, reorder_64: 1'b1, bram_cs: 4'b0000},
        '{base_addr: 25'h020_0000, reorder_64: 1'b0, bram_cs: 4'b0000},
        '{base_addr: 25'h030_0000, reorder_64: 1'b1, bram_cs: 4'b0000},
        '{base_addr: 25'h000_0000, reorder_64: 1'b0, bram_cs: 4'b0001},
        '{base_addr: 25'h000_0000, reorder_64: 1'b0, bram_cs: 4'b0010},
        '{base_addr: 25'h000_0000, reorder_64: 1'b0, bram_cs: 4'b0100},
        '{base_addr: 25'h000_0000, reorder_64: 1'b0, bram_cs: 4'b1000},
        '{base_addr: 25'h040_0000, reorder_64: 1'b0, bram_cs: 4'b0000},
        '{base_addr: 25'h050_0000, reorder_64: 1'b0, bram_cs: 4'b0000},
        '{base_addr: 25'h060_0000, reorder_64: 1'b0, bram_cs: 4'b0000},
        '{base_addr: 25'h070_0000, reorder_64: 1'b0, bram_cs: 4'b0000},
        '{base_addr: 25'h080_0000, reorder_64: 1'b0, bram_cs: 4'b0000},
        '{base_addr: 25'h090_0000, reorder_64: 1'b0, bram_cs: 4'b0000},
        '{base_addr: 25'h0a0_0000, reorder_64: 1'b0, bram_cs: 4'b0000},
        '{base_addr: 25'h0b0_0000, reorder_64: 1'b0, bram_cs: 4'b0000}
    };

endpackage

// File: rom_download_macros.svh
//====================================================================
// Width and count macros for the ROM download path
//====================================================================

`ifndef ROM_DOWNLOAD_MACROS_SVH
`define ROM_DOWNLOAD_MACROS_SVH

// SDRAM side works on byte addresses
`define ROM_SDR_ADDR_W 25

// Block RAM address covers the largest on-chip ROM
`define ROM_BRAM_ADDR_W 20

// One chip select per block RAM
`define ROM_BRAM_CS_W 4

// Region table depth and the index width that selects an entry
`define ROM_REGION_COUNT 16
`define ROM_REGION_IDX_W 4

// Record sizes arrive as three big-endian bytes
`define ROM_SIZE_W 24

`endif
